// File: flist.f
source/cpu_pkg.sv
source/dec_if.sv
source/ctrl_if.sv
source/idecoder.sv
source/controller.sv
source/datapath.sv
source/cpu.sv
test/cpu_props.sv
test/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f flist.f

output=$(./obj_dir/Vtb_cpu 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: test/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int n_tests    = 8;
    localparam int n_body     = 40;
    localparam int prog_len   = n_body + 9;                  // body, eight stores, halt
    localparam int max_cycles = n_tests * (n_body * 12 + 200);

    logic       clk = 1'b0;
    logic       arst_n;
    addr_t      start_pc;
    word_t      ram_r_data = '0;
    addr_t      ram_addr;
    logic       ram_w_en;
    word_t      ram_w_data;
    word_t      out;
    logic [2:0] status;
    logic       halted;

    word_t      mem [256];
    word_t      model_mem [256];
    word_t      model_regs [8];
    logic [2:0] model_flags;
    addr_t      exp_addr [$];
    word_t      exp_data [$];
    addr_t      gen_pc;
    integer     seed = 32'h8cedd29d;
    int         cycles = 0;
    int         writes_seen;
    int         ldr_neg = 0;
    int         ldr_pos = 0;
    addr_t      seen_addr;
    logic       seen_w_en;
    word_t      seen_w_data;
    logic       seen_halted;

    cpu dut0 (.*);

    bind controller cpu_props props0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .state    (state),
        .ram_w_en (ram_w_en),
        .halted   (halted),
        .load_ir  (load_ir)
    );

    always #50 clk = ~clk;

    task automatic fail_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            fail_run("data value mismatch");
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            fail_run("address mismatch");
        end
    endtask

    task automatic check_flags(string name, logic [2:0] got, logic [2:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            fail_run("flag mismatch");
        end
    endtask

    task automatic check_level(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            fail_run("control level mismatch");
        end
    endtask

    // one clock of the ram model, outputs sampled mid-cycle and every store checked
    task automatic tick();
        @(negedge clk);
        seen_addr   = ram_addr;
        seen_w_en   = ram_w_en;
        seen_w_data = ram_w_data;
        seen_halted = halted;
        @(posedge clk);
        ram_r_data <= mem[seen_addr];
        if (seen_w_en === 1'b1) begin
            if (exp_addr.size() == 0)
                fail_run("store seen after the last expected store");
            check_addr("ram_addr", seen_addr, exp_addr.pop_front());
            check_word("ram_w_data", seen_w_data, exp_data.pop_front());
            mem[seen_addr] = seen_w_data;
            writes_seen++;
        end
        cycles++;
        if (cycles > max_cycles)
            fail_run($sformatf("timeout after %0d cycles without reaching halt", cycles));
    endtask

    function automatic int pick(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic instr_t enc(opcode_t opc, alu_op_t op, int rn, logic [7:0] low);
        instr_t w;
        w.i.opcode = opc;
        w.i.op     = op;
        w.i.rn     = 3'(rn);
        w.i.imm8   = low; // rd, sh, rm in register format
        return w;
    endfunction

    function automatic word_t shifted(word_t v, shift_t s);
        case (s)
            sh_lsl:  return {v[14:0], 1'b0};
            sh_lsr:  return {1'b0, v[15:1]};
            sh_asr:  return {v[15], v[15:1]};
            default: return v;
        endcase
    endfunction

    // places one instruction and runs it on the reference model
    task automatic emit(instr_t w);
        word_t a, b, r, sx5, sum;
        int    wide; // exact signed result of add or cmp
        mem[gen_pc] = w;
        gen_pc      = gen_pc + 1'b1;
        a   = model_regs[w.r.rn];
        b   = shifted(model_regs[w.r.rm], w.r.sh);
        sx5 = {{11{w.i.imm8[4]}}, w.i.imm8[4:0]};
        sum = a + sx5;
        case (w.r.opcode)
            op_mov: begin
                if (w.r.op == mov_imm_op)
                    model_regs[w.i.rn] = {{8{w.i.imm8[7]}}, w.i.imm8};
                else
                    model_regs[w.r.rd] = b;
            end
            op_alu: begin
                case (w.r.op)
                    alu_add: begin
                        r    = a + b;
                        wide = int'($signed(a)) + int'($signed(b));
                    end
                    alu_cmp: begin
                        r    = a - b;
                        wide = int'($signed(a)) - int'($signed(b));
                    end
                    alu_and: r = a & b;
                    default: r = ~b;
                endcase
                if (w.r.op == alu_add || w.r.op == alu_cmp)
                    model_flags = {r[15], wide > 32767 || wide < -32768, r == 16'h0};
                if (w.r.op != alu_cmp)
                    model_regs[w.r.rd] = r;
            end
            op_ldr: model_regs[w.r.rd] = model_mem[sum[7:0]];
            op_str: begin
                model_mem[sum[7:0]] = model_regs[w.r.rd];
                exp_addr.push_back(sum[7:0]);
                exp_data.push_back(model_regs[w.r.rd]);
            end
            default: ;
        endcase
    endtask

    // r7 holds the data base and is never a destination of the random body
    task automatic build_program(output addr_t pc0);
        addr_t  base;
        instr_t w;
        int     rd;
        int     imm5;
        pc0  = addr_t'(pick(256));
        base = pc0 + addr_t'(prog_len + 16 + pick(256 - prog_len - 31));
        for (int a = 0; a < 256; a++)
            mem[a] = {8'he0, 8'(a)}; // stray fetches land on halt
        for (int a = -16; a < 16; a++)
            mem[base + addr_t'(a)] = word_t'($random(seed));
        model_mem   = mem;
        model_flags = '0;
        exp_addr.delete();
        exp_data.delete();
        gen_pc = pc0;
        for (int k = 0; k < 7; k++)
            emit(enc(op_mov, mov_imm_op, k, 8'(pick(256))));
        emit(enc(op_mov, mov_imm_op, 7, base));
        for (int k = 8; k < n_body; k++) begin
            rd   = pick(7);
            imm5 = pick(32);
            case (pick(6))
                0: w = enc(op_mov, mov_imm_op, rd, 8'(pick(256)));
                1: w = enc(op_mov, alu_add, pick(8), {3'(rd), shift_t'(pick(4)), 3'(pick(8))});
                2, 3: w = enc(op_alu, alu_op_t'(pick(4)), pick(8),
                              {3'(rd), shift_t'(pick(4)), 3'(pick(8))});
                4: begin
                    w = enc(op_ldr, alu_add, 7, {3'(rd), 5'(imm5)});
                    if (imm5 >= 16) ldr_neg++;
                    else if (imm5 > 0) ldr_pos++;
                end
                default: w = enc(op_str, alu_add, 7, {3'(pick(8)), 5'(imm5)});
            endcase
            emit(w);
        end
        for (int k = 0; k < 8; k++)
            emit(enc(op_str, alu_add, 7, {3'(k), 5'(k - 8)}));
        emit(enc(op_halt, alu_add, 0, 8'h00));
    endtask

    initial begin
        addr_t pc0;
        int    n_exp;
        word_t last_data;
        arst_n   <= 1'b0;
        start_pc <= '0;
        for (int t = 0; t < n_tests; t++) begin
            build_program(pc0);
            n_exp       = exp_addr.size();
            last_data   = exp_data[$];
            writes_seen = 0;
            arst_n   <= 1'b0;
            start_pc <= pc0;
            repeat (8) begin
                tick();
                check_level("ram_w_en", seen_w_en, 1'b0);
                check_level("halted", seen_halted, 1'b0);
            end
            arst_n <= 1'b1;
            tick();
            tick();
            check_addr("ram_addr", seen_addr, pc0); // first fetch in s_if1
            check_level("halted", seen_halted, 1'b0);
            while (seen_halted !== 1'b1)
                tick();
            check_flags("status", status, model_flags);
            check_word("out", out, last_data); // c keeps the word of the last store
            if (writes_seen != n_exp)
                fail_run($sformatf("%0d stores seen, %0d expected", writes_seen, n_exp));
            repeat (4) begin
                tick();
                check_level("ram_w_en", seen_w_en, 1'b0);
                check_level("halted", seen_halted, 1'b1);
            end
        end
        if (ldr_neg == 0 || ldr_pos == 0)
            fail_run("random programs missed LDR with a negative or a positive offset");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/cpu_props.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_props import cpu_pkg::*; (
    input logic   clk,
    input logic   arst_n,
    input state_t state,
    input logic   ram_w_en,
    input logic   halted,
    input logic   load_ir
);

    // the only memory write comes from the last step of str
    wen_in_str_w: assert property (@(posedge clk) disable iff (!arst_n)
        ram_w_en |-> state == s_str_w && $past(state) == s_str_d)
        else $error("ram_w_en high outside s_str_w");

    halted_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted)
        else $error("halted dropped without a reset");

    load_ir_in_if2: assert property (@(posedge clk) disable iff (!arst_n)
        load_ir |-> state == s_if2 && $past(state) == s_if1)
        else $error("load_ir high outside s_if2");

endmodule

`default_nettype wire

// File: source/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  addr_t      start_pc,
    input  word_t      ram_r_data,
    output addr_t      ram_addr,
    output logic       ram_w_en,
    output word_t      ram_w_data,
    output word_t      out,
    output logic [2:0] status,
    output logic       halted
);

    instr_t ir;
    addr_t  pc, data_addr, next_pc;
    logic   load_ir, load_pc, clear_pc, load_addr, sel_addr;

    dec_if  dec_i ();
    ctrl_if ctl_i ();

    idecoder u_idecoder (
        .ir  (ir),
        .dec (dec_i),
        .ctl (ctl_i)
    );

    controller u_controller (
        .clk       (clk),
        .arst_n    (arst_n),
        .opcode    (dec_i.op),
        .op        (dec_i.alu_op),
        .ctl       (ctl_i),
        .load_ir   (load_ir),
        .load_pc   (load_pc),
        .clear_pc  (clear_pc),
        .load_addr (load_addr),
        .sel_addr  (sel_addr),
        .ram_w_en  (ram_w_en),
        .halted    (halted)
    );

    datapath u_datapath (
        .clk          (clk),
        .arst_n       (arst_n),
        .mdata        (ram_r_data),
        .dec          (dec_i),
        .ctl          (ctl_i),
        .datapath_out (out),
        .status       (status)
    );

    assign next_pc    = clear_pc ? start_pc : pc + addr_t'(1);
    assign ram_addr   = sel_addr ? pc : data_addr;
    assign ram_w_data = out; // store data sits in C

    always_ff @(posedge clk) begin
        if (load_ir)   ir        <= instr_t'(ram_r_data);
        if (load_pc)   pc        <= next_pc;
        if (load_addr) data_addr <= out[addr_w-1:0];
    end

endmodule

`default_nettype wire

// File: source/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  word_t      mdata,
    dec_if.dst         dec,
    ctrl_if.dst        ctl,
    output word_t      datapath_out,
    output logic [2:0] status
);

    word_t regs [1 << reg_addr_w];
    word_t r_data, w_data;
    word_t a_q, b_q, c_q;
    word_t b_sh, ain, bin, alu_out;
    logic  ovf;

    always_comb begin
        case (ctl.wb_sel)
            wb_mem:  w_data = mdata;
            wb_imm8: w_data = dec.sximm8;
            default: w_data = c_q;
        endcase
    end

    assign r_data = regs[dec.r_addr];

    always_ff @(posedge clk) begin
        if (ctl.w_en) regs[dec.w_addr] <= w_data;
        if (ctl.en_a) a_q <= r_data;
        if (ctl.en_b) b_q <= r_data;
        if (ctl.en_c) c_q <= alu_out;
    end

    always_comb begin
        case (dec.shift_op)
            sh_lsl:  b_sh = {b_q[data_w-2:0], 1'b0};
            sh_lsr:  b_sh = {1'b0, b_q[data_w-1:1]};
            sh_asr:  b_sh = {b_q[data_w-1], b_q[data_w-1:1]};
            default: b_sh = b_q;
        endcase
    end

    assign ain = ctl.sel_a ? '0 : a_q;
    assign bin = ctl.sel_b ? dec.sximm5 : b_sh;

    always_comb begin
        ovf = 1'b0;
        case (dec.alu_op)
            alu_add: begin
                alu_out = ain + bin;
                ovf     = (ain[data_w-1] == bin[data_w-1]) &&
                          (alu_out[data_w-1] != ain[data_w-1]);
            end
            alu_cmp: begin
                alu_out = ain - bin;
                ovf     = (ain[data_w-1] != bin[data_w-1]) &&
                          (alu_out[data_w-1] != ain[data_w-1]);
            end
            alu_and: alu_out = ain & bin;
            default: alu_out = ~bin;
        endcase
    end

    // flags kept as {N, V, Z}
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            status <= 3'b000;
        else if (ctl.en_status)
            status <= {alu_out[data_w-1], ovf, alu_out == '0};
    end

    assign datapath_out = c_q;

endmodule

`default_nettype wire

// File: source/controller.sv
`timescale 1ns/100ps
`default_nettype none

module controller import cpu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  opcode_t opcode,
    input  alu_op_t op,
    ctrl_if.src     ctl,
    output logic    load_ir,
    output logic    load_pc,
    output logic    clear_pc,
    output logic    load_addr,
    output logic    sel_addr,
    output logic    ram_w_en,
    output logic    halted
);

    state_t state, next_state;
    logic   mov_imm;
    logic   is_mem;

    // opcode and op come from the instruction register, stable while executing
    assign mov_imm = (opcode == op_mov) && (op == mov_imm_op);
    assign is_mem  = (opcode == op_ldr) || (opcode == op_str);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) state <= s_reset;
        else         state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            s_reset:  next_state = s_if1;
            s_if1:    next_state = s_if2;
            s_if2:    next_state = s_upc;
            s_upc:    next_state = s_dec;
            s_dec: begin
                case (opcode)
                    op_mov:         next_state = mov_imm ? s_wb : s_rd_b;
                    op_alu:         next_state = s_rd_a;
                    op_ldr, op_str: next_state = s_rd_a;
                    default:        next_state = s_halt; // halt and unknown codes
                endcase
            end
            s_rd_a:   next_state = (opcode == op_alu) ? s_rd_b : s_exec;
            s_rd_b:   next_state = s_exec;
            s_exec: begin
                if (is_mem)
                    next_state = s_addr;
                else if (opcode == op_alu && op == alu_cmp)
                    next_state = s_if1; // cmp only touches the flags
                else
                    next_state = s_wb;
            end
            s_wb:     next_state = s_if1;
            s_addr:   next_state = (opcode == op_ldr) ? s_mem_rd : s_str_d;
            s_mem_rd: next_state = s_mem_wb;
            s_mem_wb: next_state = s_if1;
            s_str_d:  next_state = s_str_w;
            s_str_w:  next_state = s_if1;
            default:  next_state = s_halt;
        endcase
    end

    always_comb begin
        ctl.w_en      = 1'b0;
        ctl.en_a      = 1'b0;
        ctl.en_b      = 1'b0;
        ctl.en_c      = 1'b0;
        ctl.sel_a     = 1'b0;
        ctl.sel_b     = 1'b0;
        ctl.en_status = 1'b0;
        ctl.wb_sel    = wb_c;
        ctl.reg_sel   = rs_rd;
        load_ir       = 1'b0;
        load_pc       = 1'b0;
        clear_pc      = 1'b0;
        load_addr     = 1'b0;
        sel_addr      = 1'b1; // program counter on the bus by default
        ram_w_en      = 1'b0;
        halted        = 1'b0;
        case (state)
            s_reset: begin
                clear_pc = 1'b1;
                load_pc  = 1'b1;
            end
            s_if2:   load_ir = 1'b1;
            s_upc:   load_pc = 1'b1;
            s_rd_a: begin
                ctl.reg_sel = rs_rn;
                ctl.en_a    = 1'b1;
            end
            s_rd_b: begin
                ctl.reg_sel = rs_rm;
                ctl.en_b    = 1'b1;
            end
            s_exec: begin
                ctl.en_c      = 1'b1;
                ctl.sel_a     = (opcode == op_mov);
                ctl.sel_b     = is_mem;                         // base plus offset
                ctl.en_status = (opcode == op_alu) && (op == alu_add || op == alu_cmp);
            end
            s_wb: begin
                ctl.w_en    = 1'b1;
                ctl.wb_sel  = mov_imm ? wb_imm8 : wb_c;
                ctl.reg_sel = mov_imm ? rs_rn : rs_rd;
            end
            s_addr: begin
                load_addr   = 1'b1;
                ctl.reg_sel = rs_rd; // rd into B, needed by str
                ctl.en_b    = 1'b1;
            end
            s_mem_rd: sel_addr = 1'b0;
            s_mem_wb: begin
                sel_addr    = 1'b0;
                ctl.w_en    = 1'b1;
                ctl.wb_sel  = wb_mem;
            end
            s_str_d: begin
                ctl.sel_a = 1'b1;
                ctl.en_c  = 1'b1;
            end
            s_str_w: begin
                sel_addr = 1'b0;
                ram_w_en = 1'b1;
            end
            s_halt:  halted = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/idecoder.sv
`timescale 1ns/100ps
`default_nettype none

module idecoder import cpu_pkg::*; (
    input  instr_t         ir,
    dec_if.src             dec,
    ctrl_if.dst_dec        ctl
);

    logic imm_form;

    // mov #imm8, ldr and str carry an immediate where the shift field sits
    assign imm_form = (ir.r.opcode == op_mov && ir.r.op == mov_imm_op) ||
                      ir.r.opcode == op_ldr || ir.r.opcode == op_str;

    always_comb begin
        case (ctl.reg_sel)
            rs_rn:   dec.r_addr = ir.r.rn;
            rs_rd:   dec.r_addr = ir.r.rd;
            default: dec.r_addr = ir.r.rm;
        endcase
    end

    assign dec.w_addr   = dec.r_addr; // one field select serves both ports
    assign dec.op       = ir.r.opcode;
    assign dec.alu_op   = ir.r.op;
    assign dec.shift_op = imm_form ? sh_none : ir.r.sh;

    assign dec.sximm5 = {{(data_w-5){ir.i.imm8[4]}}, ir.i.imm8[4:0]};
    assign dec.sximm8 = {{(data_w-8){ir.i.imm8[7]}}, ir.i.imm8};

endmodule

`default_nettype wire

// File: source/ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface ctrl_if import cpu_pkg::*; ();
    logic     w_en;
    logic     en_a;
    logic     en_b;
    logic     en_c;
    logic     sel_a;     // first operand forced to zero
    logic     sel_b;     // second operand is sximm5
    logic     en_status;
    wb_sel_t  wb_sel;
    reg_sel_t reg_sel;

    modport src (output w_en, en_a, en_b, en_c, sel_a, sel_b, en_status, wb_sel, reg_sel);

    modport dst (input w_en, en_a, en_b, en_c, sel_a, sel_b, en_status, wb_sel);

    // the decoder only needs the register field select
    modport dst_dec (input reg_sel);
endinterface

`default_nettype wire

// File: source/dec_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dec_if import cpu_pkg::*; ();
    logic [reg_addr_w-1:0] r_addr;
    logic [reg_addr_w-1:0] w_addr;
    alu_op_t               alu_op;
    shift_t                shift_op;
    word_t                 sximm5;
    word_t                 sximm8;
    opcode_t               op;     // read by the controller at the top

    modport src (output r_addr, w_addr, alu_op, shift_op, sximm5, sximm8, op);

    modport dst (input r_addr, w_addr, alu_op, shift_op, sximm5, sximm8);
endinterface

`default_nettype wire

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int data_w     = 16;
    localparam int addr_w     = 8;
    localparam int reg_addr_w = 3;

    typedef logic [data_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

    typedef enum logic [2:0] {
        op_alu  = 3'b101,
        op_mov  = 3'b110,
        op_ldr  = 3'b011,
        op_str  = 3'b100,
        op_halt = 3'b111
    } opcode_t;

    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_cmp = 2'b01,
        alu_and = 2'b10,
        alu_mvn = 2'b11
    } alu_op_t;

    // mov with op 10 is the immediate form, op 00 the register form
    localparam alu_op_t mov_imm_op = alu_and;

    typedef enum logic [1:0] {
        sh_none = 2'b00,
        sh_lsl  = 2'b01,
        sh_lsr  = 2'b10,
        sh_asr  = 2'b11
    } shift_t;

    typedef enum logic [1:0] {wb_c, wb_mem, wb_imm8} wb_sel_t;

    typedef enum logic [1:0] {rs_rn, rs_rd, rs_rm} reg_sel_t;

    typedef struct packed {
        opcode_t                opcode;
        alu_op_t                op;
        logic [reg_addr_w-1:0] rn;
        logic [reg_addr_w-1:0] rd;
        shift_t                 sh;
        logic [reg_addr_w-1:0] rm;
    } instr_reg_t;

    typedef struct packed {
        opcode_t                opcode;
        alu_op_t                op;
        logic [reg_addr_w-1:0] rn;
        logic [7:0]             imm8; // imm5 is the low five bits
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef enum logic [3:0] {
        s_reset, s_if1, s_if2, s_upc, s_dec,
        s_rd_a, s_rd_b, s_exec, s_wb,
        s_addr, s_mem_rd, s_mem_wb, s_str_d, s_str_w,
        s_halt
    } state_t;

endpackage

`default_nettype wire
